/* tb.f */
+incdir+include
verilog/tnoc_flit_pkg.sv
verilog/tnoc_packet_pkg.sv
verilog/tnoc_flit_if.sv
verilog/tnoc_packet_packer.sv
verilog/tnoc_flit_fifo.sv
verilog/tnoc_packet_unpacker.sv
verilog/tnoc_packet_link.sv
testbench/tb_tnoc_packet_link.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the packet link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_tnoc_packet_link \
  -Mdir obj_dir -o sim_tnoc_packet_link > compile.log 2>&1
if [ $? -ne 0 ]; then
  echo "compile failed, see compile.log"
  exit 1
fi

./obj_dir/sim_tnoc_packet_link > sim.log 2>&1
run_status=$?

if grep -qxF '** PASS **' sim.log; then
  if [ $run_status -ne 0 ]; then
    echo "simulator returned status $run_status, see sim.log"
    exit 1
  fi
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see sim.log"
exit 1

/* testbench/tb_tnoc_packet_link.sv */
`include "tnoc_defs.svh"

module tb_tnoc_packet_link
  import tnoc_flit_pkg::*, tnoc_packet_pkg::*;
();
  localparam int num_packets = 200;

  logic                               clk;
  logic                               rst_n;
  logic                               send_header_valid;
  logic                               send_header_ready;
  tnoc_packet_type_e                  send_packet_type;
  logic [`TNOC_ID_WIDTH-1:0]          send_destination_id;
  logic [`TNOC_ID_WIDTH-1:0]          send_source_id;
  logic [`TNOC_TAG_WIDTH-1:0]         send_tag;
  logic [`TNOC_BURST_LENGTH_WIDTH:0]  send_burst_length;
  logic [`TNOC_ADDRESS_WIDTH-1:0]     send_address;
  logic [`TNOC_STATUS_WIDTH-1:0]      send_status;
  logic                               send_payload_valid;
  logic                               send_payload_ready;
  logic                               send_payload_last;
  logic [`TNOC_DATA_WIDTH-1:0]        send_data;
  logic [`TNOC_BYTE_ENABLE_WIDTH-1:0] send_byte_enable;
  logic                               recv_header_valid;
  logic                               recv_header_ready;
  tnoc_packet_type_e                  recv_packet_type;
  logic [`TNOC_ID_WIDTH-1:0]          recv_destination_id;
  logic [`TNOC_ID_WIDTH-1:0]          recv_source_id;
  logic [`TNOC_TAG_WIDTH-1:0]         recv_tag;
  logic [`TNOC_BURST_LENGTH_WIDTH:0]  recv_burst_length;
  logic [`TNOC_ADDRESS_WIDTH-1:0]     recv_address;
  logic [`TNOC_STATUS_WIDTH-1:0]      recv_status;
  logic                               recv_payload_valid;
  logic                               recv_payload_ready;
  logic                               recv_payload_last;
  logic [`TNOC_DATA_WIDTH-1:0]        recv_data;
  logic [`TNOC_BYTE_ENABLE_WIDTH-1:0] recv_byte_enable;

  // reference model, one entry per header or payload beat sent.
  tnoc_common_header_t  header_queue[$];
  tnoc_request_header_t request_queue[$];
  int                   length_queue[$];
  tnoc_payload_t        payload_queue[$];
  logic                 last_queue[$];

  tnoc_common_header_t  seen_header;
  tnoc_request_header_t seen_request;
  tnoc_payload_t        seen_payload;
  int                   planned_flits = 0;
  int                   cycle_count = 0;
  logic                 packet_started = 1'b0;

  tnoc_packet_link dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string what);
    report_failure($sformatf("MISMATCH at time %0t: %s", $time, what));
  endtask

  task automatic compare_header(
    input tnoc_common_header_t  expected,
    input tnoc_common_header_t  actual,
    input int                   expected_length,
    input int                   actual_length,
    input tnoc_request_header_t expected_request,
    input tnoc_request_header_t actual_request
  );
    logic is_request;
    is_request = (expected.packet_type == tnoc_write_request) ||
                 (expected.packet_type == tnoc_read_request);
    if (actual.packet_type !== expected.packet_type) begin
      report_mismatch($sformatf("packet type %0d, expected %0d",
                                actual.packet_type, expected.packet_type));
    end
    if (actual.destination_id !== expected.destination_id) begin
      report_mismatch($sformatf("destination id %0h, expected %0h",
                                actual.destination_id, expected.destination_id));
    end
    if (actual.source_id !== expected.source_id) begin
      report_mismatch($sformatf("source id %0h, expected %0h",
                                actual.source_id, expected.source_id));
    end
    if (actual.tag !== expected.tag) begin
      report_mismatch($sformatf("tag %0h, expected %0h", actual.tag, expected.tag));
    end
    if (actual.status !== expected.status) begin
      report_mismatch($sformatf("status %0h, expected %0h", actual.status, expected.status));
    end
    if (actual_length != expected_length) begin
      report_mismatch($sformatf("burst length %0d, expected %0d",
                                actual_length, expected_length));
    end
    if (is_request && (actual_request.address !== expected_request.address)) begin
      report_mismatch($sformatf("address %08h, expected %08h",
                                actual_request.address, expected_request.address));
    end
  endtask

  task automatic compare_payload(
    input tnoc_payload_t expected,
    input tnoc_payload_t actual,
    input logic          expected_last,
    input logic          actual_last
  );
    if (actual.data !== expected.data) begin
      report_mismatch($sformatf("payload data %08h, expected %08h",
                                actual.data, expected.data));
    end
    if (actual.byte_enable !== expected.byte_enable) begin
      report_mismatch($sformatf("byte enable %0h, expected %0h",
                                actual.byte_enable, expected.byte_enable));
    end
    if (actual_last !== expected_last) begin
      report_mismatch($sformatf("payload_last %0b, expected %0b", actual_last, expected_last));
    end
  endtask

  // called a small delay after a rising edge, returns at the same phase.
  task automatic send_packet();
    tnoc_packet_type_e    packet_type;
    tnoc_common_header_t  header;
    tnoc_request_header_t request;
    tnoc_payload_t        payload;
    int                   length;
    int                   beats;
    logic                 is_request;
    logic                 accepted;
    packet_type = tnoc_packet_type_e'($urandom_range(0, 3));
    is_request  = (packet_type == tnoc_write_request) || (packet_type == tnoc_read_request);
    length      = ($urandom_range(0, 19) == 0) ? 256 : int'($urandom_range(1, 16));
    beats       = ((packet_type == tnoc_write_request) ||
                   (packet_type == tnoc_read_response)) ? length : 0;
    header                = '0;
    header.packet_type    = packet_type;
    header.destination_id = 4'($urandom);
    header.source_id      = 4'($urandom);
    header.tag            = 4'($urandom);
    header.status         = 2'($urandom);
    request               = '0;
    request.address       = $urandom;
    planned_flits = planned_flits + (is_request ? 2 : 1) + beats;
    header_queue.push_back(header);
    request_queue.push_back(request);
    length_queue.push_back(length);

    packet_started      = 1'b1;
    send_header_valid   = 1'b1;
    send_packet_type    = packet_type;
    send_destination_id = header.destination_id;
    send_source_id      = header.source_id;
    send_tag            = header.tag;
    send_status         = header.status;
    send_burst_length   = 9'(length);
    send_address        = request.address;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = send_header_ready;  // transfer happens on the coming edge.
      @(posedge clk);
      #1;
    end
    send_header_valid = 1'b0;

    for (int beat = 1; beat <= beats; beat++) begin
      payload.data        = $urandom;
      payload.byte_enable = 4'($urandom);
      payload_queue.push_back(payload);
      last_queue.push_back(beat == beats);
      send_payload_valid = 1'b1;
      send_payload_last  = (beat == beats);
      send_data          = payload.data;
      send_byte_enable   = payload.byte_enable;
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        accepted = send_payload_ready;
        @(posedge clk);
        #1;
      end
    end
    send_payload_valid = 1'b0;
    send_payload_last  = 1'b0;
  endtask

  initial begin
    recv_header_ready  = 1'b0;
    recv_payload_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      recv_header_ready  = 1'($urandom);
      recv_payload_ready = 1'($urandom);
    end
  end

  // outputs are stable from the falling edge to the next rising edge.
  always @(negedge clk) begin
    if (!packet_started && ((recv_header_valid !== 1'b0) || (recv_payload_valid !== 1'b0))) begin
      report_mismatch("receive valid high before any packet was sent");
    end
    if (recv_header_valid && (header_queue.size() == 0)) begin
      report_failure("a header arrived while no packet was outstanding");
    end else if (recv_header_valid && recv_header_ready) begin
      seen_header                = '0;
      seen_header.packet_type    = recv_packet_type;
      seen_header.destination_id = recv_destination_id;
      seen_header.source_id      = recv_source_id;
      seen_header.tag            = recv_tag;
      seen_header.status         = recv_status;
      seen_request               = '0;
      seen_request.address       = recv_address;
      compare_header(header_queue.pop_front(), seen_header, length_queue.pop_front(),
                     int'(recv_burst_length), request_queue.pop_front(), seen_request);
    end
    if (recv_payload_valid && (payload_queue.size() == 0)) begin
      report_failure("a payload beat arrived while none was outstanding");
    end else if (recv_payload_valid && recv_payload_ready) begin
      seen_payload.data        = recv_data;
      seen_payload.byte_enable = recv_byte_enable;
      compare_payload(payload_queue.pop_front(), seen_payload, last_queue.pop_front(),
                      recv_payload_last);
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > 4 * planned_flits + 1000) begin
      report_failure($sformatf(
        "run timed out after %0d cycles, %0d headers and %0d beats outstanding",
        cycle_count, header_queue.size(), payload_queue.size()));
    end
  end

  initial begin
    void'($urandom(32'h05b202e2));
    rst_n               = 1'b0;
    send_header_valid   = 1'b0;
    send_packet_type    = tnoc_write_request;
    send_destination_id = '0;
    send_source_id      = '0;
    send_tag            = '0;
    send_burst_length   = 9'd1;
    send_address        = '0;
    send_status         = '0;
    send_payload_valid  = 1'b0;
    send_payload_last   = 1'b0;
    send_data           = '0;
    send_byte_enable    = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (3) begin  // idle, recv valids must stay low.
      @(posedge clk);
      #1;
    end
    for (int n = 0; n < num_packets; n++) begin
      send_packet();
      repeat ($urandom_range(0, 2)) begin
        @(posedge clk);
        #1;
      end
    end
    while ((header_queue.size() != 0) || (payload_queue.size() != 0)) begin
      @(posedge clk);
    end
    repeat (2 * `TNOC_FIFO_DEPTH + 2) @(posedge clk);  // any extra flit shows up here.
    $display("** PASS **");
    $finish;
  end
endmodule

/* verilog/tnoc_packet_link.sv */
`include "tnoc_defs.svh"

module tnoc_packet_link
  import tnoc_packet_pkg::*;
(
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               send_header_valid,
  output logic                               send_header_ready,
  input  tnoc_packet_type_e                  send_packet_type,
  input  logic [`TNOC_ID_WIDTH-1:0]          send_destination_id,
  input  logic [`TNOC_ID_WIDTH-1:0]          send_source_id,
  input  logic [`TNOC_TAG_WIDTH-1:0]         send_tag,
  input  logic [`TNOC_BURST_LENGTH_WIDTH:0]  send_burst_length,
  input  logic [`TNOC_ADDRESS_WIDTH-1:0]     send_address,
  input  logic [`TNOC_STATUS_WIDTH-1:0]      send_status,
  input  logic                               send_payload_valid,
  output logic                               send_payload_ready,
  input  logic                               send_payload_last,
  input  logic [`TNOC_DATA_WIDTH-1:0]        send_data,
  input  logic [`TNOC_BYTE_ENABLE_WIDTH-1:0] send_byte_enable,
  output logic                               recv_header_valid,
  input  logic                               recv_header_ready,
  output tnoc_packet_type_e                  recv_packet_type,
  output logic [`TNOC_ID_WIDTH-1:0]          recv_destination_id,
  output logic [`TNOC_ID_WIDTH-1:0]          recv_source_id,
  output logic [`TNOC_TAG_WIDTH-1:0]         recv_tag,
  output logic [`TNOC_BURST_LENGTH_WIDTH:0]  recv_burst_length,
  output logic [`TNOC_ADDRESS_WIDTH-1:0]     recv_address,
  output logic [`TNOC_STATUS_WIDTH-1:0]      recv_status,
  output logic                               recv_payload_valid,
  input  logic                               recv_payload_ready,
  output logic                               recv_payload_last,
  output logic [`TNOC_DATA_WIDTH-1:0]        recv_data,
  output logic [`TNOC_BYTE_ENABLE_WIDTH-1:0] recv_byte_enable
);
  tnoc_flit_if packer_flit_if();
  tnoc_flit_if fifo_flit_if();

  tnoc_packet_packer u_packer (
    .clk            (clk                ),
    .rst_n          (rst_n              ),
    .header_valid   (send_header_valid  ),
    .header_ready   (send_header_ready  ),
    .packet_type    (send_packet_type   ),
    .destination_id (send_destination_id),
    .source_id      (send_source_id     ),
    .tag            (send_tag           ),
    .burst_length   (send_burst_length  ),
    .address        (send_address       ),
    .status         (send_status        ),
    .payload_valid  (send_payload_valid ),
    .payload_ready  (send_payload_ready ),
    .payload_last   (send_payload_last  ),
    .data           (send_data          ),
    .byte_enable    (send_byte_enable   ),
    .flit_out_if    (packer_flit_if     )
  );

  tnoc_flit_fifo u_fifo (
    .clk         (clk           ),
    .rst_n       (rst_n         ),
    .flit_in_if  (packer_flit_if),
    .flit_out_if (fifo_flit_if  )
  );

  tnoc_packet_unpacker u_unpacker (
    .clk            (clk                ),
    .rst_n          (rst_n              ),
    .flit_in_if     (fifo_flit_if       ),
    .header_valid   (recv_header_valid  ),
    .header_ready   (recv_header_ready  ),
    .packet_type    (recv_packet_type   ),
    .destination_id (recv_destination_id),
    .source_id      (recv_source_id     ),
    .tag            (recv_tag           ),
    .burst_length   (recv_burst_length  ),
    .address        (recv_address       ),
    .status         (recv_status        ),
    .payload_valid  (recv_payload_valid ),
    .payload_ready  (recv_payload_ready ),
    .payload_last   (recv_payload_last  ),
    .data           (recv_data          ),
    .byte_enable    (recv_byte_enable   )
  );
endmodule

/* verilog/tnoc_packet_unpacker.sv */
`include "tnoc_defs.svh"

module tnoc_packet_unpacker
  import tnoc_flit_pkg::*, tnoc_packet_pkg::*;
(
  input  logic                               clk,
  input  logic                               rst_n,
  tnoc_flit_if.target                        flit_in_if,
  output logic                               header_valid,
  input  logic                               header_ready,
  output tnoc_packet_type_e                  packet_type,
  output logic [`TNOC_ID_WIDTH-1:0]          destination_id,
  output logic [`TNOC_ID_WIDTH-1:0]          source_id,
  output logic [`TNOC_TAG_WIDTH-1:0]         tag,
  output logic [`TNOC_BURST_LENGTH_WIDTH:0]  burst_length,
  output logic [`TNOC_ADDRESS_WIDTH-1:0]     address,
  output logic [`TNOC_STATUS_WIDTH-1:0]      status,
  output logic                               payload_valid,
  input  logic                               payload_ready,
  output logic                               payload_last,
  output logic [`TNOC_DATA_WIDTH-1:0]        data,
  output logic [`TNOC_BYTE_ENABLE_WIDTH-1:0] byte_enable
);
  logic                 flit_count;
  logic                 payload_open;
  logic                 header_flit;
  logic                 last_header_flit;
  logic                 flit_ack;
  tnoc_common_header_t  header_buffer;
  tnoc_common_header_t  common_header;
  tnoc_request_header_t request_header;
  tnoc_payload_t        payload;

  assign header_flit      = (flit_in_if.kind == tnoc_header_flit);
  assign common_header    = flit_count ? header_buffer : tnoc_common_header_t'(flit_in_if.data);
  assign request_header   = tnoc_request_header_t'(flit_in_if.data);
  assign payload          = tnoc_payload_t'(flit_in_if.data);
  assign last_header_flit =
    ({1'b0, flit_count} == (header_flits(common_header.packet_type) - 2'd1));

  // early header flits are taken without waiting on the consumer.
  assign flit_in_if.ready = header_flit ? (!last_header_flit || header_ready) : payload_ready;
  assign flit_ack         = flit_in_if.valid && flit_in_if.ready;

  assign header_valid   = flit_in_if.valid && header_flit && last_header_flit;
  assign packet_type    = common_header.packet_type;
  assign destination_id = common_header.destination_id;
  assign source_id      = common_header.source_id;
  assign tag            = common_header.tag;
  assign burst_length   = decode_burst_length(common_header.burst_length);
  assign status         = common_header.status;
  assign address        = request_header.address;  // meaningful for requests only.

  assign payload_valid = flit_in_if.valid && !header_flit;
  assign payload_last  = flit_in_if.tail;
  assign data          = payload.data;
  assign byte_enable   = payload.byte_enable;

  always_ff @(posedge clk) begin
    if (flit_ack && header_flit && !last_header_flit) begin
      header_buffer <= tnoc_common_header_t'(flit_in_if.data);
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      flit_count   <= 1'b0;
      payload_open <= 1'b0;
    end else if (flit_ack && header_flit) begin
      flit_count <= !last_header_flit;
      if (last_header_flit) begin
        payload_open <= has_payload(common_header.packet_type);
      end
    end else if (flit_ack && flit_in_if.tail) begin
      payload_open <= 1'b0;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    flit_in_if.valid && header_flit |-> !payload_open)
    else $error("header flit inside an open payload");

  assert property (@(posedge clk) disable iff (!rst_n)
    flit_in_if.valid && !header_flit |-> payload_open)
    else $error("payload flit without a header that carries payload");
endmodule

/* verilog/tnoc_flit_fifo.sv */
`include "tnoc_defs.svh"

module tnoc_flit_fifo
  import tnoc_flit_pkg::*;
#(
  parameter type entry_t = tnoc_flit_t
)(
  input logic            clk,
  input logic            rst_n,
  tnoc_flit_if.target    flit_in_if,
  tnoc_flit_if.initiator flit_out_if
);
  localparam int depth       = `TNOC_FIFO_DEPTH;
  localparam int ptr_width   = (depth > 1) ? $clog2(depth) : 1;
  localparam int count_width = $clog2(depth + 1);

  entry_t                 mem [depth];
  logic [ptr_width-1:0]   wr_ptr;
  logic [ptr_width-1:0]   rd_ptr;
  logic [count_width-1:0] count;
  logic                   push;
  logic                   pop;
  tnoc_flit_t             in_flit;
  tnoc_flit_t             out_flit;

  function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
    return (ptr == ptr_width'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_flit.kind = flit_in_if.kind;
  assign in_flit.tail = flit_in_if.tail;
  assign in_flit.data = flit_in_if.data;

  assign flit_in_if.ready = (count != count_width'(depth));
  assign push             = flit_in_if.valid && flit_in_if.ready;
  assign pop              = flit_out_if.valid && flit_out_if.ready;

  // output comes straight from storage, so a new entry shows a cycle later.
  assign out_flit          = tnoc_flit_t'(mem[rd_ptr]);
  assign flit_out_if.valid = (count != '0);
  assign flit_out_if.kind  = out_flit.kind;
  assign flit_out_if.tail  = out_flit.tail;
  assign flit_out_if.data  = out_flit.data;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= entry_t'(in_flit);
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // an occupied slot under the write pointer means the buffer is full.
  assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (count == '0) || (wr_ptr != rd_ptr))
    else $error("write into a full FIFO");

  assert property (@(posedge clk) disable iff (!rst_n)
    flit_out_if.valid && !flit_out_if.ready |=> flit_out_if.valid && $stable(out_flit))
    else $error("FIFO output dropped or changed before it was taken");
endmodule

/* verilog/tnoc_packet_packer.sv */
`include "tnoc_defs.svh"

module tnoc_packet_packer
  import tnoc_flit_pkg::*, tnoc_packet_pkg::*;
(
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               header_valid,
  output logic                               header_ready,
  input  tnoc_packet_type_e                  packet_type,
  input  logic [`TNOC_ID_WIDTH-1:0]          destination_id,
  input  logic [`TNOC_ID_WIDTH-1:0]          source_id,
  input  logic [`TNOC_TAG_WIDTH-1:0]         tag,
  input  logic [`TNOC_BURST_LENGTH_WIDTH:0]  burst_length,
  input  logic [`TNOC_ADDRESS_WIDTH-1:0]     address,
  input  logic [`TNOC_STATUS_WIDTH-1:0]      status,
  input  logic                               payload_valid,
  output logic                               payload_ready,
  input  logic                               payload_last,
  input  logic [`TNOC_DATA_WIDTH-1:0]        data,
  input  logic [`TNOC_BYTE_ENABLE_WIDTH-1:0] byte_enable,
  tnoc_flit_if.initiator                     flit_out_if
);
  logic                              flit_count;  // header flit index.
  logic                              payload_phase;
  logic [`TNOC_BURST_LENGTH_WIDTH:0] beats_left;
  logic                              last_header_flit;
  logic                              header_flit_ack;
  logic                              payload_flit_ack;
  tnoc_common_header_t               common_header;
  tnoc_request_header_t              request_header;
  tnoc_payload_t                     payload;

  always_comb begin
    common_header                = '0;
    common_header.packet_type    = packet_type;
    common_header.destination_id = destination_id;
    common_header.source_id      = source_id;
    common_header.tag            = tag;
    common_header.burst_length   = encode_burst_length(burst_length);
    common_header.status         = status;
    request_header               = '0;
    request_header.address       = address;
  end

  assign payload.data        = data;
  assign payload.byte_enable = byte_enable;
  assign last_header_flit    = ({1'b0, flit_count} == (header_flits(packet_type) - 2'd1));

  assign flit_out_if.valid = payload_phase ? payload_valid : header_valid;
  assign flit_out_if.kind  = payload_phase ? tnoc_payload_flit : tnoc_header_flit;
  assign flit_out_if.tail  = payload_phase ? payload_last :
                             (last_header_flit && !has_payload(packet_type));

  always_comb begin
    if (payload_phase) begin
      flit_out_if.data = payload;
    end else if (flit_count) begin
      flit_out_if.data = request_header;
    end else begin
      flit_out_if.data = common_header;
    end
  end

  assign header_ready     = !payload_phase && last_header_flit && flit_out_if.ready;
  assign payload_ready    = payload_phase && flit_out_if.ready;
  assign header_flit_ack  = !payload_phase && header_valid && flit_out_if.ready;
  assign payload_flit_ack = payload_phase && payload_valid && flit_out_if.ready;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      flit_count    <= 1'b0;
      payload_phase <= 1'b0;
      beats_left    <= '0;
    end else begin
      if (header_flit_ack) begin
        flit_count <= !last_header_flit;
        if (last_header_flit) begin
          payload_phase <= has_payload(packet_type);  // holds off the next header.
          beats_left    <= burst_length;
        end
      end
      if (payload_flit_ack) begin
        payload_phase <= !payload_last;
        beats_left    <= beats_left - 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    payload_flit_ack |-> (payload_last == (beats_left == 1)))
    else $error("payload_last disagrees with the burst length");

  assert property (@(posedge clk) disable iff (!rst_n)
    header_valid && !header_ready |=>
      header_valid && $stable(common_header) && $stable(address))
    else $error("header changed while waiting for ready");
endmodule

/* verilog/tnoc_flit_if.sv */
`include "tnoc_defs.svh"

interface tnoc_flit_if
  import tnoc_flit_pkg::*;
();
  logic                             valid;
  logic                             ready;
  tnoc_flit_kind_e                  kind;
  logic                             tail;
  logic [`TNOC_FLIT_DATA_WIDTH-1:0] data;

  modport initiator (
    output valid,
    input  ready,
    output kind,
    output tail,
    output data
  );

  modport target (
    input  valid,
    output ready,
    input  kind,
    input  tail,
    input  data
  );
endinterface

/* verilog/tnoc_packet_pkg.sv */
`include "tnoc_defs.svh"

package tnoc_packet_pkg;
  localparam int common_header_width = 2 + 2 * `TNOC_ID_WIDTH + `TNOC_TAG_WIDTH +
                                       `TNOC_BURST_LENGTH_WIDTH + `TNOC_STATUS_WIDTH;

  typedef enum logic [1:0] {
    tnoc_write_request  = 2'b00,
    tnoc_read_request   = 2'b01,
    tnoc_read_response  = 2'b10,
    tnoc_write_response = 2'b11
  } tnoc_packet_type_e;

  // header flit 0.
  typedef struct packed {
    logic [`TNOC_FLIT_DATA_WIDTH-common_header_width-1:0] reserved;
    logic [`TNOC_STATUS_WIDTH-1:0]                        status;
    logic [`TNOC_BURST_LENGTH_WIDTH-1:0]                  burst_length;
    logic [`TNOC_TAG_WIDTH-1:0]                           tag;
    logic [`TNOC_ID_WIDTH-1:0]                            source_id;
    logic [`TNOC_ID_WIDTH-1:0]                            destination_id;
    tnoc_packet_type_e                                    packet_type;
  } tnoc_common_header_t;

  // header flit 1, requests only.
  typedef struct packed {
    logic [`TNOC_FLIT_DATA_WIDTH-`TNOC_ADDRESS_WIDTH-1:0] reserved;
    logic [`TNOC_ADDRESS_WIDTH-1:0]                       address;
  } tnoc_request_header_t;

  function automatic logic [`TNOC_BURST_LENGTH_WIDTH-1:0] encode_burst_length(
    input logic [`TNOC_BURST_LENGTH_WIDTH:0] burst_length
  );
    logic [`TNOC_BURST_LENGTH_WIDTH:0] length_minus_one;
    length_minus_one = burst_length - 1'b1;
    return length_minus_one[`TNOC_BURST_LENGTH_WIDTH-1:0];  // 256 wraps to 8'hff.
  endfunction

  function automatic logic [`TNOC_BURST_LENGTH_WIDTH:0] decode_burst_length(
    input logic [`TNOC_BURST_LENGTH_WIDTH-1:0] encoded_length
  );
    return {1'b0, encoded_length} + 1'b1;
  endfunction

  function automatic logic has_payload(input tnoc_packet_type_e packet_type);
    return (packet_type == tnoc_write_request) || (packet_type == tnoc_read_response);
  endfunction

  function automatic logic [1:0] header_flits(input tnoc_packet_type_e packet_type);
    if ((packet_type == tnoc_write_request) || (packet_type == tnoc_read_request)) begin
      return 2'd2;
    end
    return 2'd1;
  endfunction
endpackage

/* verilog/tnoc_flit_pkg.sv */
`include "tnoc_defs.svh"

package tnoc_flit_pkg;
  typedef enum logic {
    tnoc_header_flit  = 1'b0,
    tnoc_payload_flit = 1'b1
  } tnoc_flit_kind_e;

  // one payload beat fills a whole flit.
  typedef struct packed {
    logic [`TNOC_DATA_WIDTH-1:0]        data;
    logic [`TNOC_BYTE_ENABLE_WIDTH-1:0] byte_enable;
  } tnoc_payload_t;

  typedef struct packed {
    tnoc_flit_kind_e                  kind;
    logic                             tail;  // final flit of a packet.
    logic [`TNOC_FLIT_DATA_WIDTH-1:0] data;
  } tnoc_flit_t;
endpackage

/* include/tnoc_defs.svh */
`ifndef TNOC_DEFS_SVH
`define TNOC_DEFS_SVH

`define TNOC_FLIT_DATA_WIDTH    36  // payload data plus byte enables.
`define TNOC_DATA_WIDTH         32
`define TNOC_BYTE_ENABLE_WIDTH  4
`define TNOC_ADDRESS_WIDTH      32
`define TNOC_ID_WIDTH           4
`define TNOC_TAG_WIDTH          4
`define TNOC_BURST_LENGTH_WIDTH 8   // encoded as length minus one.
`define TNOC_STATUS_WIDTH       2
`define TNOC_FIFO_DEPTH         4

`endif
